// File: verilog/exu_params.svh
// Execute stage parameters
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// Datapath width
`define EXU_XLEN 32

// PC width, bit 0 is always zero
`define EXU_PCW 31

// Bypass sources: R-stage result, load result, X-stage result
`define EXU_NBYP 3

// One quotient bit per iteration
`define EXU_DIV_ITER 32

// Accepted divide to write pulse, counted in cycles
`define EXU_DIV_LAT (`EXU_DIV_ITER + 2)

`endif

// File: verilog/exu_pkg.sv
// Execute stage shared types
package exu_pkg;

   // Operation codes from decode
   typedef enum logic [4:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      SLL,
      SRL,
      SRA,
      SLT,
      SLTU,
      MUL,    // Low half of product
      MULH,   // High half, signed x signed
      MULHU,  // High half, unsigned x unsigned
      DIV,
      DIVU,
      REM,
      REMU
   } exu_op_t;

   // Functional unit an opcode is steered to
   typedef enum logic [1:0] {
      UNIT_ALU,
      UNIT_MUL,
      UNIT_DIV
   } exu_unit_t;

   // Divider sequencing
   typedef enum logic [1:0] {
      DIV_IDLE,
      DIV_RUN,   // One quotient bit per cycle
      DIV_DONE   // Sign fix-up cycle
   } exu_div_state_t;

endpackage

// File: verilog/exu_ctl.sv
// Execute stage issue control
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_ctl (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_valid,
   input  logic                 i_x_en,
   input  exu_pkg::exu_op_t     i_op,
   input  logic                 i_div_cancel,
   input  logic [`EXU_XLEN-1:0] i_alu_result,
   input  logic [`EXU_XLEN-1:0] i_mul_result,
   output logic                 o_alu_en,
   output logic                 o_mul_en,
   output logic                 o_div_load,
   output logic                 o_div_step,
   output logic                 o_div_finish,
   output logic                 o_ready,
   output logic [`EXU_XLEN-1:0] o_result_x,
   output logic                 o_result_valid,
   output logic                 o_div_wren
);
   import exu_pkg::*;

   localparam int CNT_W = $clog2(`EXU_DIV_ITER);

   exu_unit_t      unit;
   exu_div_state_t state;
   logic           issue;
   logic           mul_valid_x;
   logic [CNT_W-1:0] iter_cnt;

   always_comb begin
      case (i_op)
         MUL, MULH, MULHU:     unit = UNIT_MUL;
         DIV, DIVU, REM, REMU: unit = UNIT_DIV;
         default:              unit = UNIT_ALU;
      endcase
   end

   assign o_ready      = (state == DIV_IDLE) & ~o_div_wren;  // Held low through the write cycle
   assign issue        = i_valid & i_x_en & o_ready;
   assign o_alu_en     = issue & (unit == UNIT_ALU);
   assign o_mul_en     = issue & (unit == UNIT_MUL);
   assign o_div_load   = issue & (unit == UNIT_DIV);
   assign o_div_step   = (state == DIV_RUN) & ~i_div_cancel;
   assign o_div_finish = (state == DIV_DONE);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state      <= DIV_IDLE;
         iter_cnt   <= '0;
         o_div_wren <= 1'b0;
      end else begin
         o_div_wren <= o_div_finish;  // Result lands with the pulse
         case (state)
            DIV_IDLE: begin
               if (o_div_load) begin
                  state    <= DIV_RUN;
                  iter_cnt <= '0;
               end
            end
            DIV_RUN: begin
               if (i_div_cancel) begin
                  state <= DIV_IDLE;  // Dropped without a write
               end else if (iter_cnt == CNT_W'(`EXU_DIV_ITER - 1)) begin
                  state <= DIV_DONE;
               end else begin
                  iter_cnt <= iter_cnt + 1'b1;
               end
            end
            default: state <= DIV_IDLE;
         endcase
      end
   end

   // X-stage valid and result steering
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result_valid <= 1'b0;
         mul_valid_x    <= 1'b0;
      end else begin
         o_result_valid <= o_alu_en | o_mul_en;
         if (o_alu_en | o_mul_en) begin
            mul_valid_x <= o_mul_en;  // Keep the mux on the last result
         end
      end
   end

   assign o_result_x = mul_valid_x ? i_mul_result : i_alu_result;

   a_ready_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(o_ready) |-> $past(o_div_wren) || $past(i_div_cancel));

   a_div_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_div_wren |-> $past(o_div_load, `EXU_DIV_LAT));

endmodule

// File: verilog/exu_operand_sel.sv
// Execute stage operand select
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_operand_sel (
   input  logic [`EXU_PCW-1:0]  i_pc,
   input  logic                 i_select_pc,
   input  logic                 i_rs1_en,
   input  logic                 i_rs2_en,
   input  logic [`EXU_XLEN-1:0] i_gpr_rs1,
   input  logic [`EXU_XLEN-1:0] i_gpr_rs2,
   input  logic [`EXU_XLEN-1:0] i_immed,
   input  logic [`EXU_NBYP-1:0] i_rs1_byp_en,
   input  logic [`EXU_NBYP-1:0] i_rs2_byp_en,
   input  logic [`EXU_XLEN-1:0] i_result_r,
   input  logic [`EXU_XLEN-1:0] i_lsu_result,
   input  logic [`EXU_XLEN-1:0] i_result_x,
   output logic [`EXU_XLEN-1:0] o_rs1,
   output logic [`EXU_XLEN-1:0] o_rs2
);

   logic [`EXU_NBYP-1:0][`EXU_XLEN-1:0] byp_src;
   logic [`EXU_XLEN-1:0]                rs1_byp_data;
   logic [`EXU_XLEN-1:0]                rs2_byp_data;

   // AND-OR of the one-hot sources
   function automatic logic [`EXU_XLEN-1:0] byp_mux(
      input logic [`EXU_NBYP-1:0]                en,
      input logic [`EXU_NBYP-1:0][`EXU_XLEN-1:0] src
   );
      logic [`EXU_XLEN-1:0] data;
      data = '0;
      for (int i = 0; i < `EXU_NBYP; i++) begin
         data = data | ({`EXU_XLEN{en[i]}} & src[i]);
      end
      return data;
   endfunction

   assign byp_src[0]   = i_result_r;    // R stage
   assign byp_src[1]   = i_lsu_result;  // Load data
   assign byp_src[2]   = i_result_x;    // Own X-stage result
   assign rs1_byp_data = byp_mux(i_rs1_byp_en, byp_src);
   assign rs2_byp_data = byp_mux(i_rs2_byp_en, byp_src);

   always_comb begin
      if (|i_rs1_byp_en)    o_rs1 = rs1_byp_data;
      else if (i_select_pc) o_rs1 = {i_pc, 1'b0};  // Jumps and auipc
      else if (i_rs1_en)    o_rs1 = i_gpr_rs1;
      else                  o_rs1 = '0;
   end

   always_comb begin
      if (|i_rs2_byp_en)    o_rs2 = rs2_byp_data;
      else if (i_rs2_en)    o_rs2 = i_gpr_rs2;
      else                  o_rs2 = i_immed;
   end

   always_comb begin
      if (i_rs1_en | i_rs2_en) begin
         a_byp_onehot: assert final ($onehot0(i_rs1_byp_en) && $onehot0(i_rs2_byp_en))
            else $error("bypass enable is not one-hot");
      end
   end

endmodule

// File: verilog/exu_alu.sv
// Execute stage integer ALU
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_en,
   input  exu_pkg::exu_op_t     i_op,
   input  logic [`EXU_XLEN-1:0] i_a,
   input  logic [`EXU_XLEN-1:0] i_b,
   output logic [`EXU_XLEN-1:0] o_result
);
   import exu_pkg::*;

   localparam int SHW = $clog2(`EXU_XLEN);

   logic [SHW-1:0]       shamt;
   logic                 lt_signed;
   logic                 lt_unsigned;
   logic [`EXU_XLEN-1:0] result_d;

   assign shamt       = i_b[SHW-1:0];  // Only the low bits count
   assign lt_signed   = $signed(i_a) < $signed(i_b);
   assign lt_unsigned = i_a < i_b;

   always_comb begin
      case (i_op)
         ADD:     result_d = i_a + i_b;
         SUB:     result_d = i_a - i_b;
         AND:     result_d = i_a & i_b;
         OR:      result_d = i_a | i_b;
         XOR:     result_d = i_a ^ i_b;
         SLL:     result_d = i_a << shamt;
         SRL:     result_d = i_a >> shamt;
         SRA:     result_d = $unsigned($signed(i_a) >>> shamt);
         SLT:     result_d = `EXU_XLEN'(lt_signed);
         SLTU:    result_d = `EXU_XLEN'(lt_unsigned);
         default: result_d = '0;  // Not an ALU op
      endcase
   end

   // X-stage result register
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result <= '0;
      end else if (i_en) begin
         o_result <= result_d;
      end
   end

endmodule

// File: verilog/exu_mul.sv
// Execute stage multiplier
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_mul (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_en,
   input  exu_pkg::exu_op_t     i_op,
   input  logic [`EXU_XLEN-1:0] i_a,
   input  logic [`EXU_XLEN-1:0] i_b,
   output logic [`EXU_XLEN-1:0] o_result
);
   import exu_pkg::*;

   logic                           sgn;
   logic signed [`EXU_XLEN:0]      a_ext;
   logic signed [`EXU_XLEN:0]      b_ext;
   logic signed [2*`EXU_XLEN+1:0]  product;

   assign sgn     = (i_op == MULH);  // MUL low half is sign agnostic
   assign a_ext   = {sgn & i_a[`EXU_XLEN-1], i_a};
   assign b_ext   = {sgn & i_b[`EXU_XLEN-1], i_b};
   assign product = a_ext * b_ext;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result <= '0;
      end else if (i_en) begin
         o_result <= (i_op == MUL) ? product[`EXU_XLEN-1:0]
                                   : product[2*`EXU_XLEN-1:`EXU_XLEN];
      end
   end

endmodule

// File: verilog/exu_div.sv
// Execute stage restoring divider
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_div (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_load,
   input  logic                 i_step,
   input  logic                 i_finish,
   input  exu_pkg::exu_op_t     i_op,
   input  logic [`EXU_XLEN-1:0] i_dividend,
   input  logic [`EXU_XLEN-1:0] i_divisor,
   output logic [`EXU_XLEN-1:0] o_result
);
   import exu_pkg::*;

   logic                 is_signed;
   logic [`EXU_XLEN-1:0] a_mag;
   logic [`EXU_XLEN-1:0] b_mag;
   logic [`EXU_XLEN-1:0] quot;
   logic [`EXU_XLEN-1:0] rem;
   logic [`EXU_XLEN-1:0] dvs;
   logic [`EXU_XLEN-1:0] dividend_q;
   logic                 neg_q;
   logic                 neg_r;
   logic                 rem_sel;
   logic                 div_zero;
   logic                 ovf;
   logic [`EXU_XLEN:0]   shifted;
   logic [`EXU_XLEN:0]   diff;
   logic [`EXU_XLEN-1:0] q_fix;
   logic [`EXU_XLEN-1:0] r_fix;

   assign is_signed = (i_op == DIV) | (i_op == REM);
   assign a_mag = (is_signed & i_dividend[`EXU_XLEN-1]) ? -i_dividend : i_dividend;
   assign b_mag = (is_signed & i_divisor[`EXU_XLEN-1])  ? -i_divisor  : i_divisor;

   assign shifted = {rem, quot[`EXU_XLEN-1]};  // Bring down next dividend bit
   assign diff    = shifted - {1'b0, dvs};

   always_ff @(posedge clk) begin
      if (i_load) begin
         quot       <= a_mag;  // Dividend shifts out as quotient shifts in
         rem        <= '0;
         dvs        <= b_mag;
         dividend_q <= i_dividend;
         neg_q      <= is_signed & (i_dividend[`EXU_XLEN-1] ^ i_divisor[`EXU_XLEN-1]);
         neg_r      <= is_signed & i_dividend[`EXU_XLEN-1];
         rem_sel    <= (i_op == REM) | (i_op == REMU);
         div_zero   <= (i_divisor == '0);
         ovf        <= is_signed & (i_dividend == {1'b1, {(`EXU_XLEN-1){1'b0}}})
                       & (&i_divisor);
      end else if (i_step) begin
         if (!diff[`EXU_XLEN]) begin
            rem  <= diff[`EXU_XLEN-1:0];
            quot <= {quot[`EXU_XLEN-2:0], 1'b1};
         end else begin
            rem  <= shifted[`EXU_XLEN-1:0];  // Restore
            quot <= {quot[`EXU_XLEN-2:0], 1'b0};
         end
      end
   end

   // Sign fix-up and the RISC-V corner cases
   always_comb begin
      if (div_zero) begin
         q_fix = '1;
         r_fix = dividend_q;
      end else if (ovf) begin
         q_fix = dividend_q;
         r_fix = '0;
      end else begin
         q_fix = neg_q ? -quot : quot;
         r_fix = neg_r ? -rem : rem;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_result <= '0;
      end else if (i_finish) begin
         o_result <= rem_sel ? r_fix : q_fix;
      end
   end

endmodule

// File: verilog/exu_top.sv
// Integer execute stage
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_valid,
   input  exu_pkg::exu_op_t     i_op,
   input  logic                 i_x_en,
   input  logic [`EXU_PCW-1:0]  i_pc,
   input  logic                 i_select_pc,
   input  logic                 i_rs1_en,
   input  logic                 i_rs2_en,
   input  logic [`EXU_XLEN-1:0] i_gpr_rs1,
   input  logic [`EXU_XLEN-1:0] i_gpr_rs2,
   input  logic [`EXU_XLEN-1:0] i_immed,
   input  logic [`EXU_NBYP-1:0] i_rs1_byp_en,
   input  logic [`EXU_NBYP-1:0] i_rs2_byp_en,
   input  logic [`EXU_XLEN-1:0] i_result_r,
   input  logic [`EXU_XLEN-1:0] i_lsu_result,
   input  logic                 i_div_cancel,
   output logic                 o_ready,
   output logic [`EXU_XLEN-1:0] o_result_x,
   output logic                 o_result_valid,
   output logic [`EXU_XLEN-1:0] o_div_result,
   output logic                 o_div_wren
);

   logic                 alu_en;
   logic                 mul_en;
   logic                 div_load;
   logic                 div_step;
   logic                 div_finish;
   logic [`EXU_XLEN-1:0] rs1;
   logic [`EXU_XLEN-1:0] rs2;
   logic [`EXU_XLEN-1:0] alu_result;
   logic [`EXU_XLEN-1:0] mul_result;

   exu_ctl i_ctl (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_valid        (i_valid),
      .i_x_en         (i_x_en),
      .i_op           (i_op),
      .i_div_cancel   (i_div_cancel),
      .i_alu_result   (alu_result),
      .i_mul_result   (mul_result),
      .o_alu_en       (alu_en),
      .o_mul_en       (mul_en),
      .o_div_load     (div_load),
      .o_div_step     (div_step),
      .o_div_finish   (div_finish),
      .o_ready        (o_ready),
      .o_result_x     (o_result_x),
      .o_result_valid (o_result_valid),
      .o_div_wren     (o_div_wren)
   );

   exu_operand_sel i_operand_sel (
      .i_pc         (i_pc),
      .i_select_pc  (i_select_pc),
      .i_rs1_en     (i_rs1_en),
      .i_rs2_en     (i_rs2_en),
      .i_gpr_rs1    (i_gpr_rs1),
      .i_gpr_rs2    (i_gpr_rs2),
      .i_immed      (i_immed),
      .i_rs1_byp_en (i_rs1_byp_en),
      .i_rs2_byp_en (i_rs2_byp_en),
      .i_result_r   (i_result_r),
      .i_lsu_result (i_lsu_result),
      .i_result_x   (o_result_x),  // Back-to-back dependency
      .o_rs1        (rs1),
      .o_rs2        (rs2)
   );

   exu_alu i_alu (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_en     (alu_en),
      .i_op     (i_op),
      .i_a      (rs1),
      .i_b      (rs2),
      .o_result (alu_result)
   );

   exu_mul i_mul (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_en     (mul_en),
      .i_op     (i_op),
      .i_a      (rs1),
      .i_b      (rs2),
      .o_result (mul_result)
   );

   exu_div i_div (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_load     (div_load),
      .i_step     (div_step),
      .i_finish   (div_finish),
      .i_op       (i_op),
      .i_dividend (rs1),
      .i_divisor  (rs2),
      .o_result   (o_div_result)
   );

endmodule

// File: test/exu_checker.sv
// Execute stage result checker
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_checker (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_ready,
   input  logic                    i_result_valid,
   input  logic [`EXU_XLEN-1:0]    i_result_x,
   input  logic                    i_div_wren,
   input  logic [`EXU_XLEN-1:0]    i_div_result,
   input  logic                    i_div_cancel,
   input  exu_pkg::exu_div_state_t i_div_state,
   input  logic                    i_push,
   input  logic [`EXU_XLEN-1:0]    i_exp_data,
   input  logic                    i_exp_div,
   output int                      o_err_cnt,
   output int                      o_chk_cnt,
   output int                      o_done_cnt,
   output int                      o_cancel_cnt,
   output int                      o_pending
);

   logic [`EXU_XLEN-1:0] exp_data_q [$];
   logic                 exp_div_q  [$];
   int                   exp_cyc_q  [$];  // Cycle of the accepting edge
   int                   cyc;
   logic                 div_busy;

   task automatic compare_result(input logic is_div, input logic [`EXU_XLEN-1:0] got,
                                 input string name);
      logic [`EXU_XLEN-1:0] exp;
      logic                 exp_is_div;
      int                   lat;
      int                   want_lat;
      if (exp_data_q.size() == 0) begin
         $display("ERROR t=%0t: %s pulsed with nothing outstanding, divider state %s",
                  $time, name, i_div_state.name());
         o_err_cnt++;
      end else begin
         exp        = exp_data_q.pop_front();
         exp_is_div = exp_div_q.pop_front();
         lat        = cyc - exp_cyc_q.pop_front();
         want_lat   = exp_is_div ? `EXU_DIV_LAT : 1;
         o_done_cnt++;
         o_chk_cnt++;
         if (exp_is_div != is_div) begin
            $display("ERROR t=%0t: result came out on %s but belongs on the other port",
                     $time, name);
            o_err_cnt++;
         end else if (lat != want_lat) begin
            $display("ERROR t=%0t: %s arrived %0d cycles after issue instead of %0d",
                     $time, name, lat, want_lat);
            o_err_cnt++;
         end
         if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s expected %08h actual %08h", $time, name, exp, got);
            o_err_cnt++;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!i_rst_n) begin
         cyc          = 0;
         div_busy     = 1'b0;
         o_err_cnt    = 0;
         o_chk_cnt    = 0;
         o_done_cnt   = 0;
         o_cancel_cnt = 0;
         o_pending    = 0;
      end else begin
         cyc++;
         o_chk_cnt++;
         if (i_ready !== !div_busy) begin  // Low for the whole divide incl. write cycle
            $display("CHECK FAILED t=%0t o_ready expected %0b actual %0b",
                     $time, !div_busy, i_ready);
            o_err_cnt++;
         end
         if (i_result_valid === 1'b1) begin
            compare_result(1'b0, i_result_x, "o_result_x");
         end
         if (i_div_wren === 1'b1) begin
            compare_result(1'b1, i_div_result, "o_div_result");
            div_busy = 1'b0;
         end
         if (i_div_cancel && div_busy && exp_cyc_q.size() > 0 && cyc > exp_cyc_q[0]) begin
            exp_data_q.delete(0);  // Dropped divide never writes
            exp_div_q.delete(0);
            exp_cyc_q.delete(0);
            div_busy = 1'b0;
            o_cancel_cnt++;
         end
         if (i_push) begin
            exp_data_q.push_back(i_exp_data);
            exp_div_q.push_back(i_exp_div);
            exp_cyc_q.push_back(cyc);
            if (i_exp_div) div_busy = 1'b1;
         end
         o_pending = exp_data_q.size();
      end
   end

endmodule

// File: test/tb_exu.sv
// Execute stage testbench
`timescale 1ns/1ps
`include "exu_params.svh"

module tb_exu;
   import exu_pkg::*;

   localparam int W           = `EXU_XLEN;
   localparam int N_ALU       = 40;
   localparam int N_MUL       = 30;
   localparam int N_DIV       = 16;
   localparam int N_BYP       = 40;
   localparam int N_CANCEL    = 4;
   localparam int N_BP        = 8;
   localparam int N_OPS       = N_ALU + N_MUL + N_DIV + N_BYP + 2 * N_CANCEL + 3 * N_BP;
   localparam int WATCHDOG_NS = N_OPS * (`EXU_DIV_LAT + 2) * 10 + 2000;  // Each op as a divide

   logic                 clk;
   logic                 i_rst_n;
   logic                 i_valid;
   exu_op_t              i_op;
   logic                 i_x_en;
   logic [`EXU_PCW-1:0]  i_pc;
   logic                 i_select_pc;
   logic                 i_rs1_en;
   logic                 i_rs2_en;
   logic [W-1:0]         i_gpr_rs1;
   logic [W-1:0]         i_gpr_rs2;
   logic [W-1:0]         i_immed;
   logic [`EXU_NBYP-1:0] i_rs1_byp_en;
   logic [`EXU_NBYP-1:0] i_rs2_byp_en;
   logic [W-1:0]         i_result_r;
   logic [W-1:0]         i_lsu_result;
   logic                 i_div_cancel;
   logic                 o_ready;
   logic [W-1:0]         o_result_x;
   logic                 o_result_valid;
   logic [W-1:0]         o_div_result;
   logic                 o_div_wren;

   logic                 exp_push;
   logic [W-1:0]         exp_data;
   logic                 exp_div;
   int                   err_cnt;
   int                   chk_cnt;
   int                   done_cnt;
   int                   cancel_cnt;
   int                   pending;
   int                   issued;
   int                   tb_errs;
   integer               seed;
   logic [W-1:0]         last_x;  // Model of the X-stage result register

   exu_op_t      alu_ops [10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
   exu_op_t      mul_ops [3]  = '{MUL, MULH, MULHU};
   exu_op_t      div_ops [4]  = '{DIV, DIVU, REM, REMU};
   logic [W-1:0] edge_vals [4] = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};

   exu_top i_dut (
      .clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_op(i_op), .i_x_en(i_x_en),
      .i_pc(i_pc), .i_select_pc(i_select_pc), .i_rs1_en(i_rs1_en), .i_rs2_en(i_rs2_en),
      .i_gpr_rs1(i_gpr_rs1), .i_gpr_rs2(i_gpr_rs2), .i_immed(i_immed),
      .i_rs1_byp_en(i_rs1_byp_en), .i_rs2_byp_en(i_rs2_byp_en), .i_result_r(i_result_r),
      .i_lsu_result(i_lsu_result), .i_div_cancel(i_div_cancel), .o_ready(o_ready),
      .o_result_x(o_result_x), .o_result_valid(o_result_valid),
      .o_div_result(o_div_result), .o_div_wren(o_div_wren)
   );

   exu_checker i_checker (
      .clk(clk), .i_rst_n(i_rst_n), .i_ready(o_ready), .i_result_valid(o_result_valid),
      .i_result_x(o_result_x), .i_div_wren(o_div_wren), .i_div_result(o_div_result),
      .i_div_cancel(i_div_cancel), .i_div_state(i_dut.i_ctl.state), .i_push(exp_push),
      .i_exp_data(exp_data), .i_exp_div(exp_div), .o_err_cnt(err_cnt), .o_chk_cnt(chk_cnt),
      .o_done_cnt(done_cnt), .o_cancel_cnt(cancel_cnt), .o_pending(pending)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [W-1:0] next_rand();
      return $random(seed);
   endfunction

   // RISC-V integer and M-extension semantics
   function automatic logic [W-1:0] exu_model(input exu_op_t op, input logic [W-1:0] a,
                                              input logic [W-1:0] b);
      logic signed [2*W-1:0] sa;
      logic signed [2*W-1:0] sb;
      logic [2*W-1:0]        ua;
      logic [2*W-1:0]        ub;
      logic [2*W-1:0]        prod;
      logic [W-1:0]          res;
      logic                  div_ovf;
      sa      = {{W{a[W-1]}}, a};
      sb      = {{W{b[W-1]}}, b};
      ua      = {{W{1'b0}}, a};
      ub      = {{W{1'b0}}, b};
      prod    = '0;
      div_ovf = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);  // Most negative over minus one
      case (op)
         ADD:  res = a + b;
         SUB:  res = a - b;
         AND:  res = a & b;
         OR:   res = a | b;
         XOR:  res = a ^ b;
         SLL:  res = a << b[4:0];
         SRL:  res = a >> b[4:0];
         SRA:  res = W'(sa >>> b[4:0]);
         SLT:  res = {{(W-1){1'b0}}, sa < sb};
         SLTU: res = {{(W-1){1'b0}}, a < b};
         MUL: begin
            prod = ua * ub;
            res  = prod[W-1:0];
         end
         MULH: begin
            prod = sa * sb;
            res  = prod[2*W-1:W];
         end
         MULHU: begin
            prod = ua * ub;
            res  = prod[2*W-1:W];
         end
         DIV: begin
            if (b == '0)     res = '1;
            else if (div_ovf) res = a;
            else             res = W'(sa / sb);
         end
         REM: begin
            if (b == '0)     res = a;
            else if (div_ovf) res = '0;
            else             res = W'(sa % sb);  // Sign follows the dividend
         end
         DIVU:    res = (b == '0) ? '1 : a / b;
         REMU:    res = (b == '0) ? a : a % b;
         default: res = '0;
      endcase
      return res;
   endfunction

   function automatic exu_unit_t unit_of(input exu_op_t op);
      if (op == MUL || op == MULH || op == MULHU) return UNIT_MUL;
      if (op == DIV || op == DIVU || op == REM || op == REMU) return UNIT_DIV;
      return UNIT_ALU;
   endfunction

   function automatic logic [W-1:0] bypass_value(input logic [`EXU_NBYP-1:0] en);
      if (en[0]) return i_result_r;
      if (en[1]) return i_lsu_result;
      return last_x;
   endfunction

   function automatic logic [W-1:0] expected_rs1();
      if (i_rs1_byp_en != '0) return bypass_value(i_rs1_byp_en);
      if (i_select_pc)        return {i_pc, 1'b0};
      if (i_rs1_en)           return i_gpr_rs1;
      return '0;
   endfunction

   function automatic logic [W-1:0] expected_rs2();
      if (i_rs2_byp_en != '0) return bypass_value(i_rs2_byp_en);
      if (i_rs2_en)           return i_gpr_rs2;
      return i_immed;
   endfunction

   task automatic set_gpr(input logic [W-1:0] a, input logic [W-1:0] b);
      i_rs1_en     = 1'b1;
      i_rs2_en     = 1'b1;
      i_select_pc  = 1'b0;
      i_rs1_byp_en = '0;
      i_rs2_byp_en = '0;
      i_gpr_rs1    = a;
      i_gpr_rs2    = b;
   endtask

   task automatic set_random_sources(input logic use_byp);
      logic [W-1:0] r;
      r            = next_rand();
      i_gpr_rs1    = next_rand();
      i_gpr_rs2    = next_rand();
      i_immed      = next_rand();
      i_result_r   = next_rand();
      i_lsu_result = next_rand();
      i_pc         = `EXU_PCW'(next_rand());
      i_rs1_en     = r[0];
      i_rs2_en     = r[1];
      i_select_pc  = use_byp & r[2];
      i_rs1_byp_en = '0;
      i_rs2_byp_en = '0;
      if (use_byp && r[3]) i_rs1_byp_en[(r[5:4] == 2'd3) ? 2'd2 : r[5:4]] = 1'b1;  // X favored
      if (use_byp && r[6]) i_rs2_byp_en[(r[8:7] == 2'd3) ? 2'd2 : r[8:7]] = 1'b1;
   endtask

   // Present one op, hold it until accepted
   task automatic issue_op(input exu_op_t op);
      logic [W-1:0] a;
      logic [W-1:0] b;
      i_op    = op;
      i_valid = 1'b1;
      i_x_en  = 1'b1;
      while (!o_ready) begin
         @(posedge clk);
         #1;
      end
      a        = expected_rs1();
      b        = expected_rs2();
      exp_data = exu_model(op, a, b);
      exp_div  = (unit_of(op) == UNIT_DIV);
      exp_push = 1'b1;
      if (unit_of(op) != UNIT_DIV) last_x = exp_data;
      issued++;
      @(posedge clk);
      #1;
      i_valid  = 1'b0;
      exp_push = 1'b0;
   endtask

   initial begin
      logic [W-1:0] r;
      logic [W-1:0] r2;
      seed         = 32'h13e;
      i_rst_n      = 1'b0;
      i_valid      = 1'b0;
      i_op         = ADD;
      i_x_en       = 1'b0;
      i_pc         = '0;
      i_result_r   = '0;
      i_lsu_result = '0;
      i_div_cancel = 1'b0;
      exp_push     = 1'b0;
      exp_data     = '0;
      exp_div      = 1'b0;
      issued       = 0;
      tb_errs      = 0;
      last_x       = '0;
      set_gpr('0, '0);
      i_immed      = '0;
      repeat (8) @(posedge clk);
      #1;
      i_rst_n = 1'b1;

      for (int k = 0; k < N_ALU; k++) begin  // GPR and immediate operands
         set_random_sources(1'b0);
         r = next_rand();
         issue_op(alu_ops[r % 10]);
      end
      for (int k = 0; k < N_MUL; k++) begin
         if (k < 16) set_gpr(edge_vals[k / 4], edge_vals[k % 4]);
         else        set_gpr(next_rand(), next_rand());
         issue_op(mul_ops[k % 3]);
      end
      for (int k = 0; k < N_DIV; k++) begin
         r  = next_rand();
         r2 = next_rand();
         if (k < 4)      set_gpr(r, '0);
         else if (k < 8) set_gpr(32'h8000_0000, 32'hffff_ffff);
         else            set_gpr(r, $signed(r2) >>> (k % 24));
         issue_op(div_ops[k % 4]);
      end
      for (int k = 0; k < N_BYP; k++) begin  // Bypass, PC and back-to-back use of X
         set_random_sources(1'b1);
         r = next_rand();
         if (r[9]) issue_op(mul_ops[r % 3]);
         else      issue_op(alu_ops[r % 10]);
      end
      for (int k = 0; k < N_CANCEL; k++) begin
         set_gpr(next_rand(), next_rand() | 32'h1);
         issue_op(div_ops[k % 4]);
         r = next_rand();
         repeat (r % 20) begin
            @(posedge clk);
            #1;
         end
         i_div_cancel = 1'b1;
         @(posedge clk);
         #1;
         i_div_cancel = 1'b0;
         set_random_sources(1'b1);
         issue_op(alu_ops[k]);
      end
      for (int k = 0; k < N_BP; k++) begin  // Ops held behind a divide
         set_gpr(next_rand(), next_rand());
         issue_op(div_ops[k % 4]);
         set_random_sources(1'b1);
         issue_op(alu_ops[(k * 3) % 10]);
         set_random_sources(1'b1);
         issue_op(mul_ops[k % 3]);
      end

      while (pending != 0) begin
         @(posedge clk);
         #1;
      end
      repeat (4) @(posedge clk);
      if (done_cnt + cancel_cnt != issued) begin
         $display("ERROR: %0d ops issued, but %0d completed and %0d were cancelled",
                  issued, done_cnt, cancel_cnt);
         tb_errs++;
      end
      $display("checks %0d, errors %0d, issued %0d, completed %0d, cancelled %0d",
               chk_cnt, err_cnt + tb_errs, issued, done_cnt, cancel_cnt);
      if (err_cnt == 0 && tb_errs == 0 && chk_cnt > 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: run did not finish within %0d ns, %0d of %0d ops issued",
               WATCHDOG_NS, issued, N_OPS);
      $display("tests failed");
      $finish;
   end

endmodule

// File: exu_top.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_ctl.sv
verilog/exu_operand_sel.sv
verilog/exu_alu.sv
verilog/exu_mul.sv
verilog/exu_div.sv
verilog/exu_top.sv
test/exu_checker.sv
test/tb_exu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu -f exu_top.f -o sim_exu \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_exu)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
